//--- design/isa_pkg.sv
package isa_pkg;

    // alu operations carried down the pipe
    // addi.w reuses ALU_ADD with an immediate operand
    typedef enum logic [2:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_XOR,
        ALU_LUI,
        ALU_NOP
    } alu_op_t;

    // three-register group, matched on inst[31:15]
    localparam int unsigned OPC3R_LO = 15;
    localparam logic [16:0] OPC_ADD_W = 17'h00020;
    localparam logic [16:0] OPC_SUB_W = 17'h00022;
    localparam logic [16:0] OPC_AND   = 17'h00029;
    localparam logic [16:0] OPC_OR    = 17'h0002A;
    localparam logic [16:0] OPC_XOR   = 17'h0002B;

    // 2ri12 form, matched on inst[31:22]
    localparam int unsigned OPC_ADDI_LO = 22;
    localparam logic [9:0]  OPC_ADDI_W  = 10'h00A;

    // 1ri20 form, matched on inst[31:25]
    localparam int unsigned OPC_LU12I_LO = 25;
    localparam logic [6:0]  OPC_LU12I_W  = 7'h0A;

    // register and immediate field positions
    localparam int unsigned RD_LO   = 0;
    localparam int unsigned RJ_LO   = 5;
    localparam int unsigned RK_LO   = 10;
    localparam int unsigned SI12_LO = 10;
    localparam int unsigned SI20_LO = 5;

endpackage

//--- design/pipe_pkg.sv
package pipe_pkg;

    // data word: operands, results, instruction words
    typedef logic [31:0] word_t;

    // instruction address
    typedef logic [31:0] pc_t;

    // architectural register index
    typedef logic [4:0] reg_idx_t;

    // number of architectural registers, r0 included
    localparam int unsigned REG_COUNT = 32;

    // fetch buffer entries unless the top level says otherwise
    localparam int unsigned DEF_BUF_DEPTH = 2;

    // all-zero word, also the value of r0
    localparam word_t ZERO_WORD = 32'h0000_0000;

endpackage

//--- design/pipe_if.sv
`timescale 1ns/100ps

// fetch buffer to decode
interface fetch_link_if;
    logic            valid;
    logic            ready;
    pipe_pkg::pc_t   pc;
    pipe_pkg::word_t inst;

    modport source (output valid, output pc, output inst, input ready);
    modport sink   (input valid, input pc, input inst, output ready);
endinterface

// decode register to execute
interface exec_link_if;
    logic                 valid;
    logic                 ready;
    pipe_pkg::pc_t        pc;
    pipe_pkg::word_t      inst;
    isa_pkg::alu_op_t     op;
    logic                 wen;
    pipe_pkg::reg_idx_t   rd;
    pipe_pkg::word_t      opnd_a;
    pipe_pkg::word_t      opnd_b;

    modport source (
        output valid, output pc, output inst, output op,
        output wen, output rd, output opnd_a, output opnd_b,
        input  ready
    );
    modport sink (
        input  valid, input pc, input inst, input op,
        input  wen, input rd, input opnd_a, input opnd_b,
        output ready
    );
endinterface

// results travelling back from execute to decode
interface fwd_if;
    // instruction sitting in the decode register, alu output
    logic               ex_wen;
    pipe_pkg::reg_idx_t ex_rd;
    pipe_pkg::word_t    ex_result;
    // instruction sitting in the commit register
    logic               cm_wen;
    pipe_pkg::reg_idx_t cm_rd;
    pipe_pkg::word_t    cm_result;

    modport source (
        output ex_wen, output ex_rd, output ex_result,
        output cm_wen, output cm_rd, output cm_result
    );
    modport sink (
        input ex_wen, input ex_rd, input ex_result,
        input cm_wen, input cm_rd, input cm_result
    );
endinterface

//--- design/fetch_buffer.sv
`timescale 1ns/100ps

module fetch_buffer #(
    parameter int unsigned BUF_DEPTH = 2
) (
    input  logic            clk,
    input  logic            reset,
    input  logic            inst_valid,
    output logic            inst_ready,
    input  pipe_pkg::pc_t   inst_pc,
    input  pipe_pkg::word_t inst,
    fetch_link_if.source    out
);

    localparam int unsigned PTR_W = $clog2(BUF_DEPTH);
    localparam int unsigned CNT_W = PTR_W + 1;

    // entry storage, pc and word side by side
    pipe_pkg::pc_t   pc_mem   [BUF_DEPTH];
    pipe_pkg::word_t inst_mem [BUF_DEPTH];

    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [CNT_W-1:0] count;

    logic push;
    logic pop;

    // ready only looks at own occupancy
    assign inst_ready = (count != CNT_W'(BUF_DEPTH));
    assign push       = inst_valid && inst_ready;
    assign pop        = out.valid && out.ready;

    // head of the queue
    assign out.valid = (count != '0);
    assign out.pc    = pc_mem[rd_ptr];
    assign out.inst  = inst_mem[rd_ptr];

    always_ff @(posedge clk) begin
        if (push) begin
            pc_mem[wr_ptr]   <= inst_pc;
            inst_mem[wr_ptr] <= inst;
        end
    end

    // pointers wrap by themselves, depth is a power of two
    always_ff @(posedge clk) begin
        if (reset) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            // simultaneous push and pop keeps the count
            if (push && !pop) begin
                count <= count + 1'b1;
            end else if (pop && !push) begin
                count <= count - 1'b1;
            end
        end
    end

endmodule

//--- design/decode_stage.sv
`timescale 1ns/100ps

module decode_stage (
    input  logic                clk,
    input  logic                reset,
    fetch_link_if.sink          in,
    exec_link_if.source         out,
    fwd_if.sink                 fwd,
    output pipe_pkg::reg_idx_t  rs1_idx,
    output pipe_pkg::reg_idx_t  rs2_idx,
    input  pipe_pkg::word_t     rs1_data,
    input  pipe_pkg::word_t     rs2_data
);

    // youngest producer wins: execute, then commit, then regfile
    function automatic pipe_pkg::word_t fwd_pick(
        input pipe_pkg::reg_idx_t idx,
        input pipe_pkg::word_t    rf_val,
        input logic               ex_wen,
        input pipe_pkg::reg_idx_t ex_rd,
        input pipe_pkg::word_t    ex_val,
        input logic               cm_wen,
        input pipe_pkg::reg_idx_t cm_rd,
        input pipe_pkg::word_t    cm_val
    );
        pipe_pkg::word_t res;
        if (idx == '0) begin
            res = pipe_pkg::ZERO_WORD;
        end else if (ex_wen && ex_rd == idx) begin
            res = ex_val;
        end else if (cm_wen && cm_rd == idx) begin
            res = cm_val;
        end else begin
            res = rf_val;
        end
        return res;
    endfunction

    isa_pkg::alu_op_t   dec_op;
    logic               dec_wen;
    logic               use_imm;
    pipe_pkg::word_t    imm;
    pipe_pkg::reg_idx_t dec_rd;
    pipe_pkg::word_t    src_a;
    pipe_pkg::word_t    src_b;
    pipe_pkg::word_t    fwd_a;
    pipe_pkg::word_t    fwd_b;

    // decode-to-execute register
    logic               d_valid;
    pipe_pkg::pc_t      d_pc;
    pipe_pkg::word_t    d_inst;
    isa_pkg::alu_op_t   d_op;
    logic               d_wen;
    pipe_pkg::reg_idx_t d_rd;
    pipe_pkg::word_t    d_a;
    pipe_pkg::word_t    d_b;

    logic in_xfer;
    logic out_xfer;

    assign dec_rd  = in.inst[isa_pkg::RD_LO +: 5];
    assign rs1_idx = in.inst[isa_pkg::RJ_LO +: 5];
    assign rs2_idx = in.inst[isa_pkg::RK_LO +: 5];

    always_comb begin
        dec_op  = isa_pkg::ALU_NOP;
        use_imm = 1'b0;
        imm     = pipe_pkg::ZERO_WORD;
        // three-register forms, rk is the second source
        case (in.inst[isa_pkg::OPC3R_LO +: 17])
            isa_pkg::OPC_ADD_W: dec_op = isa_pkg::ALU_ADD;
            isa_pkg::OPC_SUB_W: dec_op = isa_pkg::ALU_SUB;
            isa_pkg::OPC_AND:   dec_op = isa_pkg::ALU_AND;
            isa_pkg::OPC_OR:    dec_op = isa_pkg::ALU_OR;
            isa_pkg::OPC_XOR:   dec_op = isa_pkg::ALU_XOR;
            default:            dec_op = isa_pkg::ALU_NOP;
        endcase
        // addi.w, sign-extended si12
        if (in.inst[isa_pkg::OPC_ADDI_LO +: 10] == isa_pkg::OPC_ADDI_W) begin
            dec_op  = isa_pkg::ALU_ADD;
            use_imm = 1'b1;
            imm     = {{20{in.inst[isa_pkg::SI12_LO + 11]}}, in.inst[isa_pkg::SI12_LO +: 12]};
        end
        // lu12i.w, si20 placed in the upper bits
        if (in.inst[isa_pkg::OPC_LU12I_LO +: 7] == isa_pkg::OPC_LU12I_W) begin
            dec_op  = isa_pkg::ALU_LUI;
            use_imm = 1'b1;
            imm     = {in.inst[isa_pkg::SI20_LO +: 20], 12'h000};
        end
    end

    // unknown encodings and writes to r0 commit without a write
    assign dec_wen = (dec_op != isa_pkg::ALU_NOP) && (dec_rd != '0);

    assign fwd_a = fwd_pick(rs1_idx, rs1_data, fwd.ex_wen, fwd.ex_rd, fwd.ex_result,
                            fwd.cm_wen, fwd.cm_rd, fwd.cm_result);
    assign fwd_b = fwd_pick(rs2_idx, rs2_data, fwd.ex_wen, fwd.ex_rd, fwd.ex_result,
                            fwd.cm_wen, fwd.cm_rd, fwd.cm_result);

    // lu12i.w takes nothing from rj
    assign src_a = (dec_op == isa_pkg::ALU_LUI) ? pipe_pkg::ZERO_WORD : fwd_a;
    assign src_b = use_imm ? imm : fwd_b;

    assign out_xfer = d_valid && out.ready;
    assign in.ready = !d_valid || out.ready;
    assign in_xfer  = in.valid && in.ready;

    always_ff @(posedge clk) begin
        if (reset) begin
            d_valid <= 1'b0;
        end else if (in_xfer) begin
            d_valid <= 1'b1;
        end else if (out_xfer) begin
            d_valid <= 1'b0;
        end
    end

    // payload only moves on an incoming transfer
    always_ff @(posedge clk) begin
        if (in_xfer) begin
            d_pc   <= in.pc;
            d_inst <= in.inst;
            d_op   <= dec_op;
            d_wen  <= dec_wen;
            d_rd   <= dec_rd;
            d_a    <= src_a;
            d_b    <= src_b;
        end
    end

    assign out.valid  = d_valid;
    assign out.pc     = d_pc;
    assign out.inst   = d_inst;
    assign out.op     = d_op;
    assign out.wen    = d_wen;
    assign out.rd     = d_rd;
    assign out.opnd_a = d_a;
    assign out.opnd_b = d_b;

endmodule

//--- design/regfile.sv
`timescale 1ns/100ps

module regfile (
    input  logic               clk,
    input  logic               reset,
    input  pipe_pkg::reg_idx_t rs1_idx,
    input  pipe_pkg::reg_idx_t rs2_idx,
    output pipe_pkg::word_t    rs1_data,
    output pipe_pkg::word_t    rs2_data,
    input  logic               wen,
    input  pipe_pkg::reg_idx_t wr_idx,
    input  pipe_pkg::word_t    wr_data
);

    // r1..r31, r0 has no storage
    pipe_pkg::word_t regs [1:pipe_pkg::REG_COUNT-1];

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 1; i < pipe_pkg::REG_COUNT; i++) begin
                regs[i] <= pipe_pkg::ZERO_WORD;
            end
        end else if (wen && wr_idx != '0) begin
            regs[wr_idx] <= wr_data;
        end
    end

    // same-cycle write is picked up by the commit forward in decode
    assign rs1_data = (rs1_idx == '0) ? pipe_pkg::ZERO_WORD : regs[rs1_idx];
    assign rs2_data = (rs2_idx == '0) ? pipe_pkg::ZERO_WORD : regs[rs2_idx];

endmodule

//--- design/execute_stage.sv
`timescale 1ns/100ps

module execute_stage (
    input  logic                clk,
    input  logic                reset,
    exec_link_if.sink           in,
    fwd_if.source               fwd,
    output logic                commit_valid,
    input  logic                commit_ready,
    output pipe_pkg::pc_t       commit_pc,
    output pipe_pkg::word_t     commit_inst,
    output logic                commit_wen,
    output pipe_pkg::reg_idx_t  commit_rd,
    output pipe_pkg::word_t     commit_wdata,
    output logic                rf_wen,
    output pipe_pkg::reg_idx_t  rf_idx,
    output pipe_pkg::word_t     rf_data
);

    pipe_pkg::word_t alu_res;

    // commit register
    logic               c_valid;
    pipe_pkg::pc_t      c_pc;
    pipe_pkg::word_t    c_inst;
    logic               c_wen;
    pipe_pkg::reg_idx_t c_rd;
    pipe_pkg::word_t    c_wdata;

    logic in_xfer;

    always_comb begin
        case (in.op)
            isa_pkg::ALU_ADD: alu_res = in.opnd_a + in.opnd_b;
            isa_pkg::ALU_SUB: alu_res = in.opnd_a - in.opnd_b;
            isa_pkg::ALU_AND: alu_res = in.opnd_a & in.opnd_b;
            isa_pkg::ALU_OR:  alu_res = in.opnd_a | in.opnd_b;
            isa_pkg::ALU_XOR: alu_res = in.opnd_a ^ in.opnd_b;
            // upper immediate already shifted in decode
            isa_pkg::ALU_LUI: alu_res = in.opnd_b;
            default:          alu_res = pipe_pkg::ZERO_WORD;
        endcase
    end

    // commit slot frees up whenever the consumer takes it
    assign in.ready = !c_valid || commit_ready;
    assign in_xfer  = in.valid && in.ready;

    always_ff @(posedge clk) begin
        if (reset) begin
            c_valid <= 1'b0;
        end else if (in.ready) begin
            c_valid <= in.valid;
        end
    end

    always_ff @(posedge clk) begin
        if (in_xfer) begin
            c_pc    <= in.pc;
            c_inst  <= in.inst;
            c_wen   <= in.wen;
            c_rd    <= in.rd;
            c_wdata <= alu_res;
        end
    end

    // forwarding taps, valid folded into each wen
    assign fwd.ex_wen    = in.valid && in.wen;
    assign fwd.ex_rd     = in.rd;
    assign fwd.ex_result = alu_res;
    assign fwd.cm_wen    = c_valid && c_wen;
    assign fwd.cm_rd     = c_rd;
    assign fwd.cm_result = c_wdata;

    assign commit_valid = c_valid;
    assign commit_pc    = c_pc;
    assign commit_inst  = c_inst;
    assign commit_wen   = c_wen;
    assign commit_rd    = c_rd;
    assign commit_wdata = c_wdata;

    // architectural write happens with the commit transfer
    assign rf_wen  = c_valid && commit_ready && c_wen;
    assign rf_idx  = c_rd;
    assign rf_data = c_wdata;

endmodule

//--- design/core_top.sv
`timescale 1ns/100ps

module core_top #(
    parameter int unsigned BUF_DEPTH = pipe_pkg::DEF_BUF_DEPTH
) (
    input  logic               clk,
    input  logic               reset,
    // instruction input
    input  logic               inst_valid,
    output logic               inst_ready,
    input  pipe_pkg::pc_t      inst_pc,
    input  pipe_pkg::word_t    inst,
    // commit trace
    output logic               commit_valid,
    input  logic               commit_ready,
    output pipe_pkg::pc_t      commit_pc,
    output pipe_pkg::word_t    commit_inst,
    output logic               commit_wen,
    output pipe_pkg::reg_idx_t commit_rd,
    output pipe_pkg::word_t    commit_wdata
);

    fetch_link_if fetch_link ();
    exec_link_if  exec_link ();
    fwd_if        fwd ();

    // regfile read and write side
    pipe_pkg::reg_idx_t rs1_idx;
    pipe_pkg::reg_idx_t rs2_idx;
    pipe_pkg::word_t    rs1_data;
    pipe_pkg::word_t    rs2_data;
    logic               rf_wen;
    pipe_pkg::reg_idx_t rf_idx;
    pipe_pkg::word_t    rf_data;

    fetch_buffer #(
        .BUF_DEPTH (BUF_DEPTH)
    ) i_fetch_buffer (
        .clk        (clk),
        .reset      (reset),
        .inst_valid (inst_valid),
        .inst_ready (inst_ready),
        .inst_pc    (inst_pc),
        .inst       (inst),
        .out        (fetch_link)
    );

    decode_stage i_decode_stage (
        .clk      (clk),
        .reset    (reset),
        .in       (fetch_link),
        .out      (exec_link),
        .fwd      (fwd),
        .rs1_idx  (rs1_idx),
        .rs2_idx  (rs2_idx),
        .rs1_data (rs1_data),
        .rs2_data (rs2_data)
    );

    regfile i_regfile (
        .clk      (clk),
        .reset    (reset),
        .rs1_idx  (rs1_idx),
        .rs2_idx  (rs2_idx),
        .rs1_data (rs1_data),
        .rs2_data (rs2_data),
        .wen      (rf_wen),
        .wr_idx   (rf_idx),
        .wr_data  (rf_data)
    );

    execute_stage i_execute_stage (
        .clk          (clk),
        .reset        (reset),
        .in           (exec_link),
        .fwd          (fwd),
        .commit_valid (commit_valid),
        .commit_ready (commit_ready),
        .commit_pc    (commit_pc),
        .commit_inst  (commit_inst),
        .commit_wen   (commit_wen),
        .commit_rd    (commit_rd),
        .commit_wdata (commit_wdata),
        .rf_wen       (rf_wen),
        .rf_idx       (rf_idx),
        .rf_data      (rf_data)
    );

endmodule

//--- dv/core_top_assert.sv
`timescale 1ns/100ps

module core_top_assert (
    input logic               clk,
    input logic               reset,
    input logic               inst_ready,
    input logic               commit_valid,
    input logic               commit_ready,
    input pipe_pkg::pc_t      commit_pc,
    input pipe_pkg::word_t    commit_inst,
    input logic               commit_wen,
    input pipe_pkg::reg_idx_t commit_rd,
    input pipe_pkg::word_t    commit_wdata
);

    // number of assertion failures so far
    int assert_errors = 0;

    // stalled commit keeps every field
    property commit_held_stable;
        @(posedge clk) disable iff (reset)
        commit_valid && !commit_ready |=>
            $stable(commit_pc) && $stable(commit_inst) && $stable(commit_wen) &&
            $stable(commit_rd) && $stable(commit_wdata);
    endproperty

    // valid only drops through a transfer
    property commit_valid_held;
        @(posedge clk) disable iff (reset)
        commit_valid && !commit_ready |=> commit_valid;
    endproperty

    property handshake_known;
        @(posedge clk) disable iff (reset)
        !$isunknown(commit_valid) && !$isunknown(inst_ready);
    endproperty

    a_commit_stable: assert property (commit_held_stable)
        else begin
            $error("commit fields changed while commit was stalled");
            assert_errors++;
        end
    a_commit_valid: assert property (commit_valid_held)
        else begin
            $error("commit_valid dropped without a transfer");
            assert_errors++;
        end
    a_known: assert property (handshake_known)
        else begin
            $error("unknown value on commit_valid or inst_ready");
            assert_errors++;
        end

endmodule

//--- dv/tb_core_top.sv
`timescale 1ns/100ps

module tb_core_top;

    localparam int DEPTH   = pipe_pkg::DEF_BUF_DEPTH;
    localparam int TIMEOUT = 100;

    logic               clk;
    logic               reset;
    logic               inst_valid;
    logic               inst_ready;
    pipe_pkg::pc_t      inst_pc;
    pipe_pkg::word_t    inst;
    logic               commit_valid;
    logic               commit_ready;
    pipe_pkg::pc_t      commit_pc;
    pipe_pkg::word_t    commit_inst;
    logic               commit_wen;
    pipe_pkg::reg_idx_t commit_rd;
    pipe_pkg::word_t    commit_wdata;

    // architectural state as the model sees it
    logic [31:0] model_regs [32];
    // accepted but not yet committed in arrival order
    logic [31:0] exp_pc   [$];
    logic [31:0] exp_inst [$];

    logic [31:0] rng;
    logic [31:0] next_pc;
    int          err_count;
    int          commit_count;
    logic        offer_en;
    // commit_ready is random (0) or held low (1) or held high (2)
    int          ready_mode;
    // what the last edge saw
    logic        accepted_now;
    logic        committed_now;
    logic        ready_seen;

    core_top #(
        .BUF_DEPTH (DEPTH)
    ) i_core_top (
        .clk          (clk),
        .reset        (reset),
        .inst_valid   (inst_valid),
        .inst_ready   (inst_ready),
        .inst_pc      (inst_pc),
        .inst         (inst),
        .commit_valid (commit_valid),
        .commit_ready (commit_ready),
        .commit_pc    (commit_pc),
        .commit_inst  (commit_inst),
        .commit_wen   (commit_wen),
        .commit_rd    (commit_rd),
        .commit_wdata (commit_wdata)
    );

    bind core_top core_top_assert i_core_top_assert (
        .clk          (clk),
        .reset        (reset),
        .inst_ready   (inst_ready),
        .commit_valid (commit_valid),
        .commit_ready (commit_ready),
        .commit_pc    (commit_pc),
        .commit_inst  (commit_inst),
        .commit_wen   (commit_wen),
        .commit_rd    (commit_rd),
        .commit_wdata (commit_wdata)
    );

    // 4 ns period
    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    function automatic logic [31:0] xorshift32(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    task automatic draw_rand(output logic [31:0] r);
        rng = xorshift32(rng);
        r = rng;
    endtask

    task automatic compare_value(input string name, input logic [31:0] expected,
                                 input logic [31:0] actual);
        if (actual !== expected) begin
            err_count++;
            $display("FAIL %s expected %h actual %h", name, expected, actual);
        end
    endtask

    // {wen, value} straight from the encoding rules
    function automatic logic [32:0] expected_write(input logic [31:0] w);
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] res;
        logic        known;
        a     = model_regs[w[9:5]];
        b     = model_regs[w[14:10]];
        known = 1'b1;
        res   = 32'h0;
        case (w[31:15])
            17'h00020: res = a + b;
            17'h00022: res = a - b;
            17'h00029: res = a & b;
            17'h0002A: res = a | b;
            17'h0002B: res = a ^ b;
            default:   known = 1'b0;
        endcase
        if (w[31:22] == 10'h00A) begin
            known = 1'b1;
            res   = a + {{20{w[21]}}, w[21:10]};
        end else if (w[31:25] == 7'h0A) begin
            known = 1'b1;
            res   = {w[24:5], 12'h000};
        end
        return {known && (w[4:0] != 5'd0), res};
    endfunction

    // registers r0..r3 only so that dependences stay tight
    task automatic make_inst(output logic [31:0] w);
        logic [31:0] r;
        logic [4:0]  rd;
        logic [4:0]  rj;
        logic [4:0]  rk;
        draw_rand(r);
        rd = {3'b000, r[21:20]};
        rj = {3'b000, r[23:22]};
        rk = {3'b000, r[25:24]};
        case (r[3:0])
            4'd0, 4'd1:        w = {17'h00020, rk, rj, rd};
            4'd2, 4'd3:        w = {17'h00022, rk, rj, rd};
            4'd4, 4'd5:        w = {17'h00029, rk, rj, rd};
            4'd6, 4'd7:        w = {17'h0002A, rk, rj, rd};
            4'd8, 4'd9:        w = {17'h0002B, rk, rj, rd};
            4'd10, 4'd11, 4'd12: w = {10'h00A, r[15:4], rj, rd};
            4'd13, 4'd14:      w = {7'h0A, r[31:12], rd};
            // top bits outside every known group
            default:           w = {7'h7F, r[28:4]};
        endcase
    endtask

    task automatic check_commit();
        logic [31:0] pc;
        logic [31:0] w;
        logic [32:0] ew;
        if (exp_pc.size() == 0) begin
            err_count++;
            $display("commit seen with no accepted instruction outstanding, pc %h", commit_pc);
        end else begin
            pc = exp_pc.pop_front();
            w  = exp_inst.pop_front();
            ew = expected_write(w);
            compare_value("commit_pc", pc, commit_pc);
            compare_value("commit_inst", w, commit_inst);
            compare_value("commit_wen", 32'(ew[32]), 32'(commit_wen));
            if (ew[32]) begin
                compare_value("commit_rd", 32'(w[4:0]), 32'(commit_rd));
                compare_value("commit_wdata", ew[31:0], commit_wdata);
                model_regs[w[4:0]] = ew[31:0];
            end
            commit_count++;
        end
    endtask

    // one clock of observing transfers at the edge and driving the next cycle
    task automatic step();
        logic [31:0] r;
        logic [31:0] w;
        @(posedge clk);
        committed_now = commit_valid && commit_ready;
        accepted_now  = inst_valid && inst_ready;
        ready_seen    = inst_ready;
        // commit checked first since an instruction accepted now cannot retire now
        if (committed_now) begin
            check_commit();
        end
        if (accepted_now) begin
            exp_pc.push_back(inst_pc);
            exp_inst.push_back(inst);
            next_pc = next_pc + 32'd4;
        end
        if (exp_pc.size() > DEPTH + 2) begin
            err_count++;
            $display("more than %0d instructions in flight", DEPTH + 2);
        end
        draw_rand(r);
        // an offer stays put until taken
        if (!inst_valid || inst_ready) begin
            if (offer_en && r[1:0] != 2'b00) begin
                make_inst(w);
                inst_valid <= 1'b1;
                inst_pc    <= next_pc;
                inst       <= w;
            end else begin
                inst_valid <= 1'b0;
            end
        end
        case (ready_mode)
            0:       commit_ready <= (r[3:2] != 2'b00);
            1:       commit_ready <= 1'b0;
            default: commit_ready <= 1'b1;
        endcase
    endtask

    initial begin
        int          n;
        int          lat;
        int          assert_fails;
        logic [31:0] w;
        reset        = 1'b1;
        inst_valid   = 1'b0;
        inst_pc      = 32'h0;
        inst         = 32'h0;
        commit_ready = 1'b0;
        rng          = 32'd19152;
        next_pc      = 32'h1c00_0000;
        err_count    = 0;
        commit_count = 0;
        offer_en     = 1'b0;
        ready_mode   = 2;
        for (int i = 0; i < 32; i++) begin
            model_regs[i] = 32'h0;
        end

        // reset for 5 cycles with state known from the second edge on
        for (n = 0; n < 5; n++) begin
            @(posedge clk);
            if (n > 0) begin
                compare_value("commit_valid", 32'h0, 32'(commit_valid));
                compare_value("inst_ready", 32'h1, 32'(inst_ready));
            end
        end
        reset        <= 1'b0;
        commit_ready <= 1'b1;
        @(posedge clk);
        compare_value("commit_valid", 32'h0, 32'(commit_valid));
        compare_value("inst_ready", 32'h1, 32'(inst_ready));

        // lone instruction through an empty pipe
        make_inst(w);
        inst_valid <= 1'b1;
        inst_pc    <= next_pc;
        inst       <= w;
        n = 0;
        do begin
            step();
            n++;
        end while (!accepted_now && n < TIMEOUT);
        if (!accepted_now) begin
            err_count++;
            $display("timed out waiting for the first instruction to be accepted");
        end
        lat = 0;
        do begin
            step();
            lat++;
        end while (!committed_now && lat < TIMEOUT);
        if (!committed_now) begin
            err_count++;
            $display("timed out waiting for the first commit");
        end else begin
            compare_value("commit latency", 32'd3, 32'(lat));
        end

        // mixed traffic with random back-pressure
        offer_en   = 1'b1;
        ready_mode = 0;
        repeat (600) step();

        // stalled commit must fill up the input side
        ready_mode = 1;
        n = 0;
        do begin
            step();
            n++;
        end while (ready_seen && n < TIMEOUT);
        if (ready_seen) begin
            err_count++;
            $display("inst_ready stayed high with commit stalled");
        end
        repeat (20) step();
        ready_mode = 0;
        repeat (400) step();

        // stop offering and drain
        offer_en   = 1'b0;
        ready_mode = 2;
        n = 0;
        do begin
            step();
            n++;
        end while ((exp_pc.size() != 0 || inst_valid) && n < TIMEOUT);
        if (exp_pc.size() != 0) begin
            err_count++;
            $display("timed out draining, %0d instructions never committed", exp_pc.size());
        end
        // any commit in a quiet pipe is extra
        repeat (10) step();

        assert_fails = i_core_top.i_core_top_assert.assert_errors;
        $display("commits checked: %0d, errors: %0d, assertion failures: %0d",
                 commit_count, err_count, assert_fails);
        if (err_count == 0 && assert_fails == 0) begin
            $display("All checks passed");
        end else begin
            $display("Checks failed");
        end
        $finish;
    end

endmodule

//--- build.f
design/isa_pkg.sv
design/pipe_pkg.sv
design/pipe_if.sv
design/fetch_buffer.sv
design/decode_stage.sv
design/regfile.sv
design/execute_stage.sv
design/core_top.sv
dv/core_top_assert.sv
dv/tb_core_top.sv

//--- Makefile
# Verilator flow for the core testbench

TOP = tb_core_top

.PHONY: all lint sim clean

all: sim

lint:
	verilator --lint-only --timing --assert --top-module $(TOP) -f build.f

# pass only if the log holds the pass line
sim:
	verilator --binary --timing --assert --top-module $(TOP) \
		-Mdir obj_dir -o sim_$(TOP) -f build.f
	./obj_dir/sim_$(TOP) | tee sim.log
	grep -q "All checks passed" sim.log

clean:
	rm -rf obj_dir sim.log
